/* Makefile */
TOP = tb_tcm_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -f tb.f --top-module $(TOP) -Mdir obj_dir

# Pass only if the pass message appears as a line of its own
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir

/* bench/access_patterns.txt */
# test we addr strb wdata err rdata, all fields hex
# rdata is compared on reads and on error responses only
# test 2, full-word write then read in each bank
2 1 00000010 f 11223344 0 00000000
2 0 00000010 0 00000000 0 11223344
2 1 10000010 f a5a55a5a 0 00000000
2 0 10000010 0 00000000 0 a5a55a5a
2 1 00000ffc f deadbeef 0 00000000
2 0 00000ffc 0 00000000 0 deadbeef
2 1 10000000 f 0badf00d 0 00000000
2 0 10000000 0 00000000 0 0badf00d
2 1 00000020 f 76543210 0 00000000
2 0 00000023 0 00000000 0 76543210
2 1 10000ffc f 01020304 0 00000000
2 0 10000ffc 0 00000000 0 01020304

# test 3, partial writes with mixed strobes
3 1 00000040 f 00000000 0 00000000
3 1 00000040 1 000000aa 0 00000000
3 1 00000040 4 00cc0000 0 00000000
3 0 00000040 0 00000000 0 00cc00aa
3 1 00000040 a 11223344 0 00000000
3 0 00000040 0 00000000 0 11cc33aa
3 1 00000040 5 ffffffff 0 00000000
3 0 00000040 0 00000000 0 11ff33ff
3 1 00000040 0 12345678 0 00000000
3 0 00000040 0 00000000 0 11ff33ff
3 1 10000040 f 89abcdef 0 00000000
3 1 10000040 6 00112200 0 00000000
3 0 10000040 0 00000000 0 891122ef
3 1 10000040 9 77000066 0 00000000
3 0 10000040 0 00000000 0 77112266
3 1 10000040 3 0000abcd 0 00000000
3 0 10000040 0 00000000 0 7711abcd

# test 4, same word index in both banks
4 1 00000190 f cafe0000 0 00000000
4 1 10000190 f 0000beef 0 00000000
4 0 00000190 0 00000000 0 cafe0000
4 0 10000190 0 00000000 0 0000beef
4 1 00000190 3 00001234 0 00000000
4 0 10000190 0 00000000 0 0000beef
4 0 00000190 0 00000000 0 cafe1234
4 1 00000000 f 13579bdf 0 00000000
4 0 00000000 0 00000000 0 13579bdf
4 0 10000000 0 00000000 0 0badf00d

# test 5, unowned regions and nonzero pad bits
5 0 20000000 0 00000000 1 00000000
5 1 20000010 f ffffffff 1 00000000
5 0 f0000040 0 00000000 1 00000000
5 1 00001010 f 99999999 1 00000000
5 0 00000010 0 00000000 0 11223344
5 1 10800040 f 55555555 1 00000000
5 0 10000040 0 00000000 0 7711abcd
5 1 30000190 f 00000000 1 00000000
5 0 00000190 0 00000000 0 cafe1234
5 0 10000190 0 00000000 0 0000beef
5 1 08000000 f 44444444 1 00000000
5 0 00000000 0 00000000 0 13579bdf
5 1 20000ffc f 00000000 1 00000000
5 0 00000ffc 0 00000000 0 deadbeef
5 0 10000ffc 0 00000000 0 01020304
5 0 ffffffff 0 00000000 1 00000000

/* bench/tb_tcm_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tcm_subsystem;

    localparam int RSP_TIMEOUT = 20;
    localparam int RESET_CYCLES = 16;
    localparam int WIN_WORDS = 16;
    localparam int WIN_BASE = 768;
    localparam int RAND_OPS = 64;

    logic              clk_neg_i = 1'b0;
    logic              rstn_neg_sync;
    bus_pkg::acc_req_t req_drv;
    bus_pkg::acc_rsp_t dut_rsp;

    int error_count;
    int check_count;
    int tests_done;
    int test_id;
    int test_errors;
    int test_checks;
    bit timed_out;

    // Reference words of the random window by region and word
    logic [31:0]       model [mem_map_pkg::BANK_NUM][WIN_WORDS];
    bus_pkg::acc_req_t stream_req [$];
    logic [31:0]       stream_exp [$];

    tcm_subsystem_top UUT (
        .clk_neg_i     (clk_neg_i),
        .rstn_neg_sync (rstn_neg_sync),
        .req_i         (req_drv),
        .rsp_o         (dut_rsp)
    );

    always #10 clk_neg_i = ~clk_neg_i;

    // ----------------------------------------------------------
    // Bookkeeping
    // ----------------------------------------------------------
    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_count++;
        test_checks++;
        if (got !== exp) begin
            error_count++;
            test_errors++;
            $display("Fail at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic string test_title(input int id);
        case (id)
            1:       return "reset state";
            2:       return "full-word write and read";
            3:       return "partial byte writes";
            4:       return "bank isolation";
            5:       return "out-of-range addresses";
            6:       return "back-to-back random accesses";
            default: return "unnamed";
        endcase
    endfunction

    task automatic start_test(input int id);
        test_id     = id;
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic finish_test();
        tests_done++;
        $display("[%0d] %s: %0d checks, %0d mismatches",
                 test_id, test_title(test_id), test_checks, test_errors);
    endtask

    // Strobed bytes take the new value
    function automatic logic [31:0] apply_strobes(input logic [31:0] old_word,
                                                  input logic [31:0] new_word,
                                                  input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // Window word in the given region with zero pad and byte offset
    function automatic logic [31:0] window_addr(input int region, input int word);
        logic [9:0] idx;
        idx = 10'(WIN_BASE + word);
        return {4'(region), 16'h0000, idx, 2'b00};
    endfunction

    // ----------------------------------------------------------
    // Single access with response wait
    // ----------------------------------------------------------
    task automatic single_access(input  logic        we,
                                 input  logic [31:0] addr,
                                 input  logic [3:0]  strb,
                                 input  logic [31:0] wdata,
                                 output logic [31:0] got_err,
                                 output logic [31:0] got_rdata);
        int waited;
        waited    = 0;
        got_err   = '0;
        got_rdata = '0;
        @(posedge clk_neg_i);
        #1;
        req_drv.req   = 1'b1;
        req_drv.we    = we;
        req_drv.strb  = strb;
        req_drv.addr  = addr;
        req_drv.wdata = wdata;
        @(posedge clk_neg_i);
        #1;
        req_drv = '0;
        // Mid-cycle after the capture edge
        @(negedge clk_neg_i);
        while (!dut_rsp.ack && waited < RSP_TIMEOUT) begin
            @(negedge clk_neg_i);
            waited++;
        end
        if (!dut_rsp.ack) begin
            timed_out = 1'b1;
            $display("Timeout at %0t: no ack within %0d cycles for address %h",
                     $time, RSP_TIMEOUT, addr);
        end else begin
            check_value(32'(waited), 32'd0, "ack delay in cycles");
            got_err   = 32'(dut_rsp.error);
            got_rdata = dut_rsp.rdata;
            // One response per request
            @(negedge clk_neg_i);
            check_value(32'(dut_rsp.ack), 32'd0, "ack held past one cycle");
        end
    endtask

    // ----------------------------------------------------------
    // Pattern file for tests 2 to 5
    // ----------------------------------------------------------
    task automatic run_pattern_file();
        int          fd;
        int          n;
        int          cur;
        string       line;
        logic [31:0] f_test;
        logic [31:0] f_we;
        logic [31:0] f_addr;
        logic [31:0] f_strb;
        logic [31:0] f_wdata;
        logic [31:0] f_err;
        logic [31:0] f_rdata;
        logic [31:0] got_err;
        logic [31:0] got_rdata;
        cur = 0;
        fd  = $fopen("bench/access_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file bench/access_patterns.txt");
            error_count++;
            return;
        end
        while (!$feof(fd) && !timed_out) begin
            line = "";
            n    = $fgets(line, fd);
            if (n == 0 || line.substr(0, 0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h",
                        f_test, f_we, f_addr, f_strb, f_wdata, f_err, f_rdata);
            if (n != 7) begin
                continue;
            end
            if (int'(f_test) != cur) begin
                if (cur != 0) begin
                    finish_test();
                end
                cur = int'(f_test);
                start_test(cur);
            end
            single_access(f_we[0], f_addr, f_strb[3:0], f_wdata, got_err, got_rdata);
            if (!timed_out) begin
                check_value(got_err, f_err, $sformatf("error flag at address %h", f_addr));
                // Read data of a write hit is don't-care
                if (!f_we[0] || f_err[0]) begin
                    check_value(got_rdata, f_rdata,
                                $sformatf("read data at address %h", f_addr));
                end
            end
        end
        if (cur != 0) begin
            finish_test();
        end
        $fclose(fd);
    endtask

    // ----------------------------------------------------------
    // Back-to-back stream for test 6
    // ----------------------------------------------------------
    task automatic build_random_stream();
        bus_pkg::acc_req_t op;
        int                r;
        int                i;
        stream_req.delete();
        stream_exp.delete();
        // Fill the window in both banks first
        for (r = 0; r < mem_map_pkg::BANK_NUM; r++) begin
            for (i = 0; i < WIN_WORDS; i++) begin
                op          = '0;
                op.req      = 1'b1;
                op.we       = 1'b1;
                op.strb     = 4'hf;
                op.addr     = window_addr(r, i);
                op.wdata    = $urandom();
                model[r][i] = op.wdata;
                stream_req.push_back(op);
                stream_exp.push_back('0);
            end
        end
        repeat (RAND_OPS) begin
            r        = int'($urandom_range(mem_map_pkg::BANK_NUM - 1, 0));
            i        = int'($urandom_range(WIN_WORDS - 1, 0));
            op       = '0;
            op.req   = 1'b1;
            op.we    = 1'($urandom());
            op.strb  = 4'($urandom());
            op.addr  = window_addr(r, i);
            op.wdata = $urandom();
            if (op.we) begin
                model[r][i] = apply_strobes(model[r][i], op.wdata, op.strb);
                stream_exp.push_back('0);
            end else begin
                stream_exp.push_back(model[r][i]);
            end
            stream_req.push_back(op);
        end
    endtask

    // Response to request k shows in the cycle of request k+1
    task automatic run_stream();
        int k;
        for (k = 0; k <= stream_req.size(); k++) begin
            @(posedge clk_neg_i);
            #1;
            if (k < stream_req.size()) begin
                req_drv = stream_req[k];
            end else begin
                req_drv = '0;
            end
            @(negedge clk_neg_i);
            if (k == 0) begin
                check_value(32'(dut_rsp.ack), 32'd0, "ack before first stream request");
            end else begin
                check_value(32'(dut_rsp.ack), 32'd1, $sformatf("stream ack for op %0d", k - 1));
                check_value(32'(dut_rsp.error), 32'd0,
                            $sformatf("stream error for op %0d", k - 1));
                if (!stream_req[k-1].we) begin
                    check_value(dut_rsp.rdata, stream_exp[k-1],
                                $sformatf("stream read data for op %0d", k - 1));
                end
            end
        end
        @(negedge clk_neg_i);
        check_value(32'(dut_rsp.ack), 32'd0, "ack after end of stream");
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(66138));
        req_drv       = '0;
        rstn_neg_sync = 1'b0;
        error_count   = 0;
        check_count   = 0;
        tests_done    = 0;
        timed_out     = 1'b0;

        start_test(1);
        repeat (RESET_CYCLES) begin
            @(posedge clk_neg_i);
            #1;
            check_value(32'(dut_rsp.ack), 32'd0, "ack during reset");
            check_value(32'(dut_rsp.error), 32'd0, "error during reset");
        end
        rstn_neg_sync = 1'b1;
        repeat (5) begin
            @(negedge clk_neg_i);
            check_value(32'(dut_rsp.ack), 32'd0, "ack while idle");
            check_value(32'(dut_rsp.error), 32'd0, "error while idle");
        end
        finish_test();

        run_pattern_file();

        if (!timed_out) begin
            start_test(6);
            build_random_stream();
            run_stream();
            finish_test();
        end

        $display("Summary: %0d tests, %0d checks, %0d mismatches, timeout %0d",
                 tests_done, check_count, error_count, timed_out);
        if (error_count == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // ----------------------------------------------------------
    // Access port widths
    // ----------------------------------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // One strobe per byte lane
    localparam int STRB_W = DATA_W / 8;

    // ----------------------------------------------------------
    // Request and response
    // ----------------------------------------------------------

    // Single-cycle strobe, no back-pressure
    typedef struct packed {
        logic              req;
        logic              we;
        logic [STRB_W-1:0] strb;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } acc_req_t;

    // Idle sources drive all zero so responses can be ORed
    typedef struct packed {
        logic              ack;
        logic              error;
        logic [DATA_W-1:0] rdata;
    } acc_rsp_t;

endpackage

`default_nettype wire

/* hdl/mem_map_pkg.sv */
`default_nettype none

package mem_map_pkg;

    // ----------------------------------------------------------
    // Region numbering
    // ----------------------------------------------------------
    localparam int REGION_W    = 4;
    localparam int ITCM_REGION = 0;
    localparam int DTCM_REGION = ITCM_REGION + 1;

    // Regions are consecutive, one bank each
    localparam int BANK_NUM = DTCM_REGION + 1;

    // First region number that no bank owns
    localparam logic [REGION_W-1:0] REGION_LIMIT = REGION_W'(BANK_NUM);

    // ----------------------------------------------------------
    // Bank geometry
    // ----------------------------------------------------------

    // 1024 words of 32 bits, 4 KB per bank
    localparam int BANK_WORDS = 1024;
    localparam int WORD_IDX_W = $clog2(BANK_WORDS);
    localparam int BYTE_OFF_W = $clog2(bus_pkg::STRB_W);

    // Bits between region and word index, zero for a valid access
    localparam int PAD_W = bus_pkg::ADDR_W - REGION_W - WORD_IDX_W - BYTE_OFF_W;

    // ----------------------------------------------------------
    // Address views
    // ----------------------------------------------------------
    typedef struct packed {
        logic [REGION_W-1:0]   region;
        logic [PAD_W-1:0]      pad;
        logic [WORD_IDX_W-1:0] word_idx;
        logic [BYTE_OFF_W-1:0] byte_off;
    } tcm_addr_fields_t;

    typedef union packed {
        logic [bus_pkg::ADDR_W-1:0] flat;
        tcm_addr_fields_t           fields;
    } tcm_addr_u;

endpackage

`default_nettype wire

/* hdl/region_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module region_decoder (
    input  wire logic              clk_neg_i,
    input  wire logic              rstn_neg_sync,
    input  bus_pkg::acc_req_t      req_i,
    output bus_pkg::acc_req_t      bank_req_o [mem_map_pkg::BANK_NUM],
    output bus_pkg::acc_rsp_t      err_rsp_o
);

    mem_map_pkg::tcm_addr_u addr_view;
    mem_map_pkg::tcm_addr_u fwd_addr;
    logic                   hit;
    logic                   err_q;

    // ----------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------
    assign addr_view.flat = req_i.addr;

    // Owned region and clean pad bits
    assign hit = (addr_view.fields.region < mem_map_pkg::REGION_LIMIT)
              && (addr_view.fields.pad == '0);

    // Banks only see their local offset
    always_comb begin
        fwd_addr.flat            = '0;
        fwd_addr.fields.word_idx = addr_view.fields.word_idx;
        fwd_addr.fields.byte_off = addr_view.fields.byte_off;
    end

    // ----------------------------------------------------------
    // Per-bank request strobes
    // ----------------------------------------------------------
    always_comb begin
        for (int b = 0; b < mem_map_pkg::BANK_NUM; b++) begin
            bank_req_o[b]      = req_i;
            bank_req_o[b].addr = fwd_addr.flat;
            // At most one bank sees the strobe
            bank_req_o[b].req  = req_i.req && hit
                              && (int'(addr_view.fields.region) == b);
        end
    end

    // ----------------------------------------------------------
    // Error response
    // ----------------------------------------------------------

    // Same one-cycle latency as a bank hit
    always_ff @(posedge clk_neg_i or negedge rstn_neg_sync) begin
        if (!rstn_neg_sync) begin
            err_q <= 1'b0;
        end else begin
            err_q <= req_i.req && !hit;
        end
    end

    // No bank answered, so read data is zero
    assign err_rsp_o.ack   = err_q;
    assign err_rsp_o.error = err_q;
    assign err_rsp_o.rdata = '0;

endmodule

`default_nettype wire

/* hdl/rsp_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module rsp_merge (
    input  bus_pkg::acc_rsp_t bank_rsp_i [mem_map_pkg::BANK_NUM],
    input  bus_pkg::acc_rsp_t err_rsp_i,
    output bus_pkg::acc_rsp_t rsp_o
);

    // ----------------------------------------------------------
    // OR of all response sources
    // ----------------------------------------------------------

    // Only one source acks per cycle, the rest are zero
    always_comb begin
        rsp_o = err_rsp_i;
        for (int b = 0; b < mem_map_pkg::BANK_NUM; b++) begin
            rsp_o.ack   = rsp_o.ack   | bank_rsp_i[b].ack;
            rsp_o.error = rsp_o.error | bank_rsp_i[b].error;
            rsp_o.rdata = rsp_o.rdata | bank_rsp_i[b].rdata;
        end
    end

endmodule

`default_nettype wire

/* hdl/tcm_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module tcm_bank (
    input  wire logic              clk_neg_i,
    input  wire logic              rstn_neg_sync,
    input  bus_pkg::acc_req_t      bank_req_i,
    output bus_pkg::acc_rsp_t      rsp_o
);

    logic [bus_pkg::DATA_W-1:0]          mem [mem_map_pkg::BANK_WORDS];
    mem_map_pkg::tcm_addr_u              addr_view;
    logic [mem_map_pkg::WORD_IDX_W-1:0]  word_idx;
    logic                                ack_q;
    logic [bus_pkg::DATA_W-1:0]          rdata_q;

    // Word index as forwarded by the decoder
    assign addr_view.flat = bank_req_i.addr;
    assign word_idx       = addr_view.fields.word_idx;

    // ----------------------------------------------------------
    // Storage
    // ----------------------------------------------------------

    // Byte-lane writes
    always_ff @(posedge clk_neg_i) begin
        if (bank_req_i.req && bank_req_i.we) begin
            for (int i = 0; i < bus_pkg::STRB_W; i++) begin
                if (bank_req_i.strb[i]) begin
                    mem[word_idx][i*8 +: 8] <= bank_req_i.wdata[i*8 +: 8];
                end
            end
        end
    end

    // Registered read, data held across writes
    always_ff @(posedge clk_neg_i) begin
        if (bank_req_i.req && !bank_req_i.we) begin
            rdata_q <= mem[word_idx];
        end
    end

    // ----------------------------------------------------------
    // Response
    // ----------------------------------------------------------
    always_ff @(posedge clk_neg_i or negedge rstn_neg_sync) begin
        if (!rstn_neg_sync) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bank_req_i.req;
        end
    end

    // Zero when idle so the merger can OR
    assign rsp_o.ack   = ack_q;
    assign rsp_o.error = 1'b0;
    assign rsp_o.rdata = ack_q ? rdata_q : '0;

endmodule

`default_nettype wire

/* hdl/tcm_subsystem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tcm_subsystem_top (
    input  wire logic              clk_neg_i,
    input  wire logic              rstn_neg_sync,
    input  bus_pkg::acc_req_t      req_i,
    output bus_pkg::acc_rsp_t      rsp_o
);

    bus_pkg::acc_req_t bank_req [mem_map_pkg::BANK_NUM];
    bus_pkg::acc_rsp_t bank_rsp [mem_map_pkg::BANK_NUM];
    bus_pkg::acc_rsp_t err_rsp;

    // ----------------------------------------------------------
    // Address decode
    // ----------------------------------------------------------
    region_decoder u_region_decoder (
        .clk_neg_i     (clk_neg_i),
        .rstn_neg_sync (rstn_neg_sync),
        .req_i         (req_i),
        .bank_req_o    (bank_req),
        .err_rsp_o     (err_rsp)
    );

    // ----------------------------------------------------------
    // Memory banks
    // ----------------------------------------------------------

    // Bank 0 holds instructions, bank 1 holds data
    for (genvar g = 0; g < mem_map_pkg::BANK_NUM; g++) begin : gen_bank
        tcm_bank u_tcm_bank (
            .clk_neg_i     (clk_neg_i),
            .rstn_neg_sync (rstn_neg_sync),
            .bank_req_i    (bank_req[g]),
            .rsp_o         (bank_rsp[g])
        );
    end

    // ----------------------------------------------------------
    // Response path
    // ----------------------------------------------------------
    rsp_merge u_rsp_merge (
        .bank_rsp_i (bank_rsp),
        .err_rsp_i  (err_rsp),
        .rsp_o      (rsp_o)
    );

endmodule

`default_nettype wire

/* tb.f */
hdl/bus_pkg.sv
hdl/mem_map_pkg.sv
hdl/region_decoder.sv
hdl/tcm_bank.sv
hdl/rsp_merge.sv
hdl/tcm_subsystem_top.sv
bench/tb_tcm_subsystem.sv
